//--- src/fetch_pkg.sv
package fetch_pkg;

  // Memory bus commands
  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_cmd_t;

  localparam int ADDR_W    = 64;
  localparam int LINE_W    = 64;
  localparam int INST_W    = 32;
  localparam int MEM_TAG_W = 4;  // Tag 0 is no transaction

  // Direct-mapped geometry, 8 byte lines
  localparam int OFS_W     = 3;
  localparam int IDX_W     = 5;
  localparam int NUM_LINES = 1 << IDX_W;
  localparam int TAG_W     = 8;

  // Address field positions
  localparam int IDX_LSB = OFS_W;
  localparam int IDX_MSB = IDX_LSB + IDX_W - 1;  // Bit 7
  localparam int TAG_LSB = IDX_MSB + 1;
  localparam int TAG_MSB = TAG_LSB + TAG_W - 1;  // Bit 15

  // Instruction word select within a line
  localparam int WORD_SEL_BIT = 2;

  typedef logic [MEM_TAG_W-1:0] mem_tag_t;
  typedef logic [IDX_W-1:0]     cache_idx_t;
  typedef logic [TAG_W-1:0]     cache_tag_t;

endpackage

//--- src/icache_mem.sv
`timescale 1ns/1ns

module icache_mem (
  input  logic                       clock,
  input  logic                       rst_n,
  input  logic                       wr_en,
  input  fetch_pkg::cache_idx_t      wr_idx,
  input  fetch_pkg::cache_tag_t      wr_tag,
  input  logic [fetch_pkg::LINE_W-1:0] wr_data,
  input  fetch_pkg::cache_idx_t      rd_idx,
  input  fetch_pkg::cache_tag_t      rd_tag,
  output logic [fetch_pkg::LINE_W-1:0] rd_data,
  output logic                       rd_hit
);

  logic [fetch_pkg::LINE_W-1:0] data_array [fetch_pkg::NUM_LINES];
  fetch_pkg::cache_tag_t        tag_array  [fetch_pkg::NUM_LINES];
  logic [fetch_pkg::NUM_LINES-1:0] valid_bits;

  // Only the valid bits come out of reset
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      valid_bits <= '0;
    end else if (wr_en) begin
      valid_bits[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) begin
      data_array[wr_idx] <= wr_data;
      tag_array[wr_idx]  <= wr_tag;
    end
  end

  // Combinational read port
  assign rd_data = data_array[rd_idx];
  assign rd_hit  = valid_bits[rd_idx] && (tag_array[rd_idx] == rd_tag);

  // A fill with an X index would corrupt an unknown line
  wr_idx_known: assert property (@(posedge clock) disable iff (!rst_n)
    wr_en |-> !$isunknown(wr_idx))
    else $error("icache_mem: write with unknown index");

endmodule

//--- src/icache_ctrl.sv
`timescale 1ns/1ns

module icache_ctrl (
  input  logic                          clock,
  input  logic                          rst_n,
  input  logic [fetch_pkg::ADDR_W-1:0]  fetch_addr,
  output logic [fetch_pkg::LINE_W-1:0]  line_data,
  output logic                          line_valid,
  output fetch_pkg::cache_idx_t         rd_idx,
  output fetch_pkg::cache_tag_t         rd_tag,
  input  logic [fetch_pkg::LINE_W-1:0]  rd_data,
  input  logic                          rd_hit,
  output logic                          wr_en,
  output fetch_pkg::cache_idx_t         wr_idx,
  output fetch_pkg::cache_tag_t         wr_tag,
  output logic [fetch_pkg::LINE_W-1:0]  wr_data,
  output fetch_pkg::bus_cmd_t           mem_command,
  output logic [fetch_pkg::ADDR_W-1:0]  mem_addr,
  input  fetch_pkg::mem_tag_t           mem_response,
  input  logic [fetch_pkg::LINE_W-1:0]  mem_data,
  input  fetch_pkg::mem_tag_t           mem_tag
);

  fetch_pkg::mem_tag_t   cur_mem_tag;  // Outstanding transaction, 0 when idle
  fetch_pkg::cache_idx_t last_idx;
  fetch_pkg::cache_tag_t last_tag;
  logic                  outstanding;
  logic                  changed_addr;
  logic                  issue_load;

  assign rd_idx = fetch_addr[fetch_pkg::IDX_MSB:fetch_pkg::IDX_LSB];
  assign rd_tag = fetch_addr[fetch_pkg::TAG_MSB:fetch_pkg::TAG_LSB];

  assign line_data  = rd_data;
  assign line_valid = rd_hit;

  assign outstanding  = (cur_mem_tag != '0);
  assign changed_addr = (rd_idx != last_idx) || (rd_tag != last_tag);

  // New request on a miss unless the same line is already in flight
  assign issue_load = rst_n && !rd_hit && (!outstanding || changed_addr);  // Quiet bus in reset

  assign mem_command = issue_load ? fetch_pkg::BUS_LOAD : fetch_pkg::BUS_NONE;
  assign mem_addr    = {fetch_addr[fetch_pkg::ADDR_W-1:fetch_pkg::OFS_W],
                        {fetch_pkg::OFS_W{1'b0}}};

  // Fill only for the line the tag was issued for
  assign wr_en   = outstanding && !changed_addr && (mem_tag == cur_mem_tag);
  assign wr_idx  = last_idx;
  assign wr_tag  = last_tag;
  assign wr_data = mem_data;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      last_idx <= '0;
      last_tag <= '0;
    end else begin
      last_idx <= rd_idx;
      last_tag <= rd_tag;
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      cur_mem_tag <= '0;
    end else if (wr_en) begin
      cur_mem_tag <= '0;
    end else if (issue_load) begin
      cur_mem_tag <= mem_response;  // Zero on a reject, so the load repeats
    end else if (changed_addr) begin
      cur_mem_tag <= '0;  // Drop the stale request
    end
  end

  // Fetch side never writes memory
  no_store: assert property (@(posedge clock) disable iff (!rst_n)
    mem_command != fetch_pkg::BUS_STORE)
    else $error("icache_ctrl: store command on the fetch bus");

  // A fill must belong to a tag memory handed out at an earlier edge
  fill_needs_tag: assert property (@(posedge clock) disable iff (!rst_n)
    wr_en |-> $past(outstanding) || ($past(mem_response) == mem_tag))
    else $error("icache_ctrl: line fill with no outstanding tag");

endmodule

//--- src/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage (
  input  logic                          clock,
  input  logic                          rst_n,
  input  logic                          get_next_inst,
  input  logic                          take_branch,
  input  logic [fetch_pkg::ADDR_W-1:0]  branch_target,
  input  logic [fetch_pkg::LINE_W-1:0]  line_data,
  input  logic                          line_valid,
  output logic [fetch_pkg::ADDR_W-1:0]  fetch_addr,
  output logic [fetch_pkg::ADDR_W-1:0]  if_pc,
  output logic [fetch_pkg::ADDR_W-1:0]  if_npc,
  output logic [fetch_pkg::INST_W-1:0]  if_ir,
  output logic                          if_valid
);

  logic [fetch_pkg::ADDR_W-1:0] pc;
  logic [fetch_pkg::ADDR_W-1:0] pc_plus4;

  assign pc_plus4   = pc + fetch_pkg::ADDR_W'(4);
  assign fetch_addr = pc;

  assign if_pc  = pc;
  assign if_npc = pc_plus4;

  // Upper word when bit 2 is set
  assign if_ir = pc[fetch_pkg::WORD_SEL_BIT] ?
                 line_data[fetch_pkg::LINE_W-1:fetch_pkg::INST_W] :
                 line_data[fetch_pkg::INST_W-1:0];

  assign if_valid = line_valid && get_next_inst && !take_branch;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (take_branch) begin
      pc <= branch_target;  // Redirect wins over advance
    end else if (if_valid) begin
      pc <= pc_plus4;
    end
  end

  // Holds across redirects too, so targets must be aligned
  pc_aligned: assert property (@(posedge clock) disable iff (!rst_n)
    pc[1:0] == 2'b00)
    else $error("fetch_stage: PC not word aligned");

endmodule

//--- src/ifetch.sv
`timescale 1ns/1ns

module ifetch (
  input  logic                          clock,
  input  logic                          rst_n,
  input  logic                          get_next_inst,
  input  logic                          take_branch,
  input  logic [fetch_pkg::ADDR_W-1:0]  branch_target,
  input  fetch_pkg::mem_tag_t           mem_response,
  input  logic [fetch_pkg::LINE_W-1:0]  mem_data,
  input  fetch_pkg::mem_tag_t           mem_tag,
  output fetch_pkg::bus_cmd_t           mem_command,
  output logic [fetch_pkg::ADDR_W-1:0]  mem_addr,
  output logic [fetch_pkg::ADDR_W-1:0]  if_pc,
  output logic [fetch_pkg::ADDR_W-1:0]  if_npc,
  output logic [fetch_pkg::INST_W-1:0]  if_ir,
  output logic                          if_valid
);

  logic [fetch_pkg::ADDR_W-1:0] fetch_addr;
  logic [fetch_pkg::LINE_W-1:0] line_data;
  logic                         line_valid;

  // Cache array wires
  fetch_pkg::cache_idx_t        rd_idx;
  fetch_pkg::cache_tag_t        rd_tag;
  logic [fetch_pkg::LINE_W-1:0] rd_data;
  logic                         rd_hit;
  logic                         wr_en;
  fetch_pkg::cache_idx_t        wr_idx;
  fetch_pkg::cache_tag_t        wr_tag;
  logic [fetch_pkg::LINE_W-1:0] wr_data;

  fetch_stage fetch_stage_0 (
    .clock         (clock),
    .rst_n         (rst_n),
    .get_next_inst (get_next_inst),
    .take_branch   (take_branch),
    .branch_target (branch_target),
    .line_data     (line_data),
    .line_valid    (line_valid),
    .fetch_addr    (fetch_addr),
    .if_pc         (if_pc),
    .if_npc        (if_npc),
    .if_ir         (if_ir),
    .if_valid      (if_valid)
  );

  icache_ctrl icache_ctrl_0 (
    .clock        (clock),
    .rst_n        (rst_n),
    .fetch_addr   (fetch_addr),
    .line_data    (line_data),
    .line_valid   (line_valid),
    .rd_idx       (rd_idx),
    .rd_tag       (rd_tag),
    .rd_data      (rd_data),
    .rd_hit       (rd_hit),
    .wr_en        (wr_en),
    .wr_idx       (wr_idx),
    .wr_tag       (wr_tag),
    .wr_data      (wr_data),
    .mem_command  (mem_command),
    .mem_addr     (mem_addr),
    .mem_response (mem_response),
    .mem_data     (mem_data),
    .mem_tag      (mem_tag)
  );

  icache_mem icache_mem_0 (
    .clock   (clock),
    .rst_n   (rst_n),
    .wr_en   (wr_en),
    .wr_idx  (wr_idx),
    .wr_tag  (wr_tag),
    .wr_data (wr_data),
    .rd_idx  (rd_idx),
    .rd_tag  (rd_tag),
    .rd_data (rd_data),
    .rd_hit  (rd_hit)
  );

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
  output logic clock,
  output logic rst_n
);

  localparam int HALF_PERIOD = 4;

  initial begin
    clock = 1'b0;
    forever #HALF_PERIOD clock = ~clock;
  end

  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clock);
    #1 rst_n = 1'b1;  // Released with the other inputs
  end

endmodule

//--- bench/tb_mem.sv
`timescale 1ns/1ns

module tb_mem (
  input  logic                          clock,
  input  logic                          rst_n,
  input  fetch_pkg::bus_cmd_t           mem_command,
  input  logic [fetch_pkg::ADDR_W-1:0]  mem_addr,
  output fetch_pkg::mem_tag_t           mem_response,
  output logic [fetch_pkg::LINE_W-1:0]  mem_data,
  output fetch_pkg::mem_tag_t           mem_tag
);

  localparam int LATENCY = 6;

  integer                       seed;
  int                           cycle;
  logic                         reject;
  logic                         accepted;
  logic [fetch_pkg::ADDR_W-1:0] accepted_addr;
  fetch_pkg::mem_tag_t          next_tag;

  // Pending returns, oldest first
  int                           due_q[$];
  fetch_pkg::mem_tag_t          tag_q[$];
  logic [fetch_pkg::ADDR_W-1:0] addr_q[$];

  // Instruction at byte address a is a inverted
  function automatic logic [fetch_pkg::LINE_W-1:0] line_at(
    input logic [fetch_pkg::ADDR_W-1:0] addr
  );
    logic [31:0] base;
    base = addr[31:0];
    return {~(base + 32'd4), ~base};
  endfunction

  assign mem_response = (rst_n && !reject && mem_command == fetch_pkg::BUS_LOAD) ?
                        next_tag : '0;

  initial begin
    seed          = 82788;
    cycle         = 0;
    reject        = 1'b0;
    accepted      = 1'b0;
    accepted_addr = '0;
    next_tag      = 4'd1;
    mem_data      = '0;
    mem_tag       = '0;
  end

  // Mid-cycle, the accept decision has settled
  always @(negedge clock) begin
    accepted      = (mem_response != '0);
    accepted_addr = mem_addr;
  end

  always @(posedge clock) begin
    #1;
    cycle = cycle + 1;
    if (accepted) begin
      due_q.push_back(cycle - 1 + LATENCY);
      tag_q.push_back(next_tag);
      addr_q.push_back(accepted_addr);
      next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;  // Tag 0 never used
      accepted = 1'b0;
    end
    mem_tag  = '0;
    mem_data = '0;
    if (due_q.size() > 0 && due_q[0] == cycle) begin
      mem_tag  = tag_q.pop_front();
      mem_data = line_at(addr_q.pop_front());
      void'(due_q.pop_front());
    end
    reject = (($random(seed) & 3) == 0);  // About one in four
  end

endmodule

//--- bench/ifetch_tb.sv
`timescale 1ns/1ns

module ifetch_tb;

  localparam int WAIT_CYCLES = 100;

  logic                         clock;
  logic                         rst_n;
  logic                         get_next_inst;
  logic                         take_branch;
  logic [fetch_pkg::ADDR_W-1:0] branch_target;
  fetch_pkg::mem_tag_t          mem_response;
  logic [fetch_pkg::LINE_W-1:0] mem_data;
  fetch_pkg::mem_tag_t          mem_tag;
  fetch_pkg::bus_cmd_t          mem_command;
  logic [fetch_pkg::ADDR_W-1:0] mem_addr;
  logic [fetch_pkg::ADDR_W-1:0] if_pc;
  logic [fetch_pkg::ADDR_W-1:0] if_npc;
  logic [fetch_pkg::INST_W-1:0] if_ir;
  logic                         if_valid;

  int checks = 0;
  int errors = 0;
  int test_start = 0;

  tb_clock clock_gen (.clock(clock), .rst_n(rst_n));
  tb_mem   mem_model (.*);
  ifetch   i_dut (.*);

  task automatic check_addr(input string name, input logic [fetch_pkg::ADDR_W-1:0] got,
                            input logic [fetch_pkg::ADDR_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_inst(input string name, input logic [fetch_pkg::INST_W-1:0] got,
                            input logic [fetch_pkg::INST_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_cmd(input string name, input fetch_pkg::bus_cmd_t got,
                           input fetch_pkg::bus_cmd_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic report_test(input string name);
    if (errors == test_start) $display("test %s: passed", name);
    else $display("test %s: %0d errors", name, errors - test_start);
    test_start = errors;
  endtask

  // One cycle of take_branch, no instruction may be valid in it
  task automatic redirect(input logic [fetch_pkg::ADDR_W-1:0] target);
    @(posedge clock);
    #1;
    take_branch   = 1'b1;
    branch_target = target;
    @(negedge clock);
    check_flag("if_valid", if_valid, 1'b0);
    @(posedge clock);
    #1;
    take_branch = 1'b0;
  endtask

  // Next valid instruction, checked against the memory rule
  task automatic fetch_one(input logic [fetch_pkg::ADDR_W-1:0] pc, input bit cmd_check,
                           input fetch_pkg::bus_cmd_t exp_cmd);
    fetch_pkg::bus_cmd_t cmd_seen;
    int                  n;
    cmd_seen = fetch_pkg::BUS_NONE;
    n = 0;
    do begin
      @(negedge clock);
      if (mem_command == fetch_pkg::BUS_LOAD) begin
        cmd_seen = fetch_pkg::BUS_LOAD;
        check_addr("mem_addr", mem_addr, pc & ~64'h7);  // Line aligned
      end
      n++;
    end while (!if_valid && n < WAIT_CYCLES);
    checks++;
    if (!if_valid) begin
      errors++;
      $display("timeout: no valid instruction for pc %h", pc);
    end else begin
      check_addr("if_pc", if_pc, pc);
      check_addr("if_npc", if_npc, pc + 64'd4);
      check_inst("if_ir", if_ir, ~pc[fetch_pkg::INST_W-1:0]);
      if (cmd_check) check_cmd("mem_command", cmd_seen, exp_cmd);
    end
  endtask

  task automatic test_reset;
    int n;
    // Still in reset at the first falling edge
    @(negedge clock);
    check_flag("if_valid", if_valid, 1'b0);
    check_addr("if_pc", if_pc, '0);
    check_cmd("mem_command", mem_command, fetch_pkg::BUS_NONE);
    n = 0;
    while (rst_n !== 1'b1 && n < 20) begin
      @(posedge clock);
      #2;
      n++;
    end
    if (rst_n !== 1'b1) begin
      errors++;
      $display("reset was never released");
    end
    // PC 0 misses in the first cycle out of reset
    @(negedge clock);
    check_cmd("mem_command", mem_command, fetch_pkg::BUS_LOAD);
    check_addr("mem_addr", mem_addr, '0);
    report_test("reset");
  endtask

  task automatic test_sequential;
    @(posedge clock);
    #1;
    get_next_inst = 1'b1;
    for (int i = 0; i < 64; i++) begin
      fetch_one(fetch_pkg::ADDR_W'(i * 4), 1'b0, fetch_pkg::BUS_NONE);
    end
    report_test("sequential");
  endtask

  task automatic test_refetch;
    redirect('0);
    for (int i = 0; i < 64; i++) begin
      fetch_one(fetch_pkg::ADDR_W'(i * 4), 1'b1, fetch_pkg::BUS_NONE);  // All hits
    end
    report_test("refetch");
  endtask

  task automatic test_redirect;
    redirect(64'h400);
    fetch_one(64'h400, 1'b0, fetch_pkg::BUS_NONE);
    report_test("redirect");
  endtask

  task automatic test_stall;
    @(posedge clock);
    #1;
    get_next_inst = 1'b0;
    repeat (8) begin
      @(negedge clock);
      check_flag("if_valid", if_valid, 1'b0);
      check_addr("if_pc", if_pc, 64'h404);
    end
    @(posedge clock);
    #1;
    get_next_inst = 1'b1;
    fetch_one(64'h404, 1'b0, fetch_pkg::BUS_NONE);
    report_test("stall");
  endtask

  // 0x100 and 0x8100 share index 0
  task automatic test_conflict;
    redirect(64'h100);
    fetch_one(64'h100, 1'b1, fetch_pkg::BUS_LOAD);
    redirect(64'h8100);
    fetch_one(64'h8100, 1'b1, fetch_pkg::BUS_LOAD);
    redirect(64'h100);
    fetch_one(64'h100, 1'b1, fetch_pkg::BUS_LOAD);
    report_test("conflict");
  endtask

  initial begin
    get_next_inst = 1'b0;
    take_branch   = 1'b0;
    branch_target = '0;
    test_reset();
    test_sequential();
    test_refetch();
    test_redirect();
    test_stall();
    test_conflict();
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- ifetch.f
src/fetch_pkg.sv
src/icache_mem.sv
src/icache_ctrl.sv
src/fetch_stage.sv
src/ifetch.sv
bench/tb_clock.sv
bench/tb_mem.sv
bench/ifetch_tb.sv

//--- Makefile
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -Wno-fatal
TOP       = ifetch_tb
FILE_LIST = ifetch.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Everything OK

.PHONY: simulate clean

simulate:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
